// File: hdl/lcache_consts.svh
`ifndef LCACHE_CONSTS_SVH
`define LCACHE_CONSTS_SVH

// ========================================
// Cache geometry
// ========================================

// Ways per set, the loader names one of these on every fill
`define LC_WAYS 4

// Sets in each way, selected by the index bits of the byte address
`define LC_SETS 32

// Bytes in one cache line, the low address bits pick a byte inside it
`define LC_LINE_BYTES 16

// ========================================
// Timing
// ========================================

// Clock edges from the strobe sample in decode to ack or err on the port
// Decode, way store and result each add one register
`define LC_PIPE_DEPTH 3

`endif

// File: hdl/lcache_pkg.sv
`default_nettype none

package lcache_pkg;

	`include "lcache_consts.svh"

	// Address split widths derived from the geometry
	localparam int LC_OFS_BITS = $clog2(`LC_LINE_BYTES); // Byte offset inside a line
	localparam int LC_IDX_BITS = $clog2(`LC_SETS);        // Set index
	localparam int LC_TAG_BITS = 32 - LC_IDX_BITS - LC_OFS_BITS; // What is left is tag

	typedef logic [31:0]                     lc_addr_t;  // Byte address
	typedef logic [LC_TAG_BITS-1:0]          lc_tag_t;   // Address bits 31 to 9
	typedef logic [LC_IDX_BITS-1:0]          lc_index_t; // Address bits 8 to 4
	typedef logic [`LC_LINE_BYTES*8-1:0]     lc_line_t;  // One whole line
	typedef logic [`LC_LINE_BYTES-1:0]       lc_sel_t;   // One bit per line byte
	typedef logic [$clog2(`LC_WAYS)-1:0]     lc_way_t;   // Way number

	// Operation carried down the pipeline
	typedef enum logic [1:0] {
		LC_OP_READ,
		LC_OP_WRITE,
		LC_OP_INVAL,
		LC_OP_LOAD
	} lc_op_e;

	// Port the item came from, the result stage answers on this port
	typedef enum logic [1:0] {
		LC_PORT_RD,
		LC_PORT_WR,
		LC_PORT_LD
	} lc_port_e;

	// Item from decode into way store
	typedef struct packed {
		logic      valid; // Stage holds a live item
		lc_op_e    op;
		lc_port_e  port;
		lc_tag_t   tag;
		lc_index_t index;
		lc_sel_t   sel;   // Write byte enables, all ones on a load
		lc_line_t  line;  // Write or load data
		lc_way_t   way;   // Target way of a load
	} lc_lookup_t;

	// Item from way store into the result stage
	typedef struct packed {
		logic     valid;
		lc_op_e   op;
		lc_port_e port;
		logic     hit;   // Tag matched in one valid way
		lc_way_t  way;   // Way that matched
		lc_line_t line;  // Line as it was before this item changed it
	} lc_result_t;

endpackage

`default_nettype wire

// File: hdl/lcache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcache_consts.svh"

module lcache_req_decode (
	input  logic                 wclk,
	input  logic                 rst,
	input  logic                 rd_cyc,
	input  logic                 rd_stb,
	input  logic                 wr_cyc,
	input  logic                 wr_stb,
	input  logic                 wr_inv,
	input  logic                 ld_cyc,
	input  logic                 ld_stb,
	input  lcache_pkg::lc_addr_t rd_adr,
	input  lcache_pkg::lc_addr_t wr_adr,
	input  lcache_pkg::lc_addr_t ld_adr,
	input  lcache_pkg::lc_sel_t  wr_sel,
	input  lcache_pkg::lc_line_t wr_dat,
	input  lcache_pkg::lc_line_t ld_dat,
	input  lcache_pkg::lc_way_t  ld_way,
	input  lcache_pkg::lc_port_e done_port,
	input  logic                 done,
	output lcache_pkg::lc_lookup_t lookup
);
	import lcache_pkg::*;

	logic [2:0] inflight_q; // One bit per port, indexed by lc_port_e
	logic [2:0] issue_vec;  // Port granted this cycle
	logic [2:0] done_vec;   // Port answered by the result stage
	logic       req_rd, req_wr, req_ld;
	lc_addr_t   sel_adr;    // Address of the winning port
	lc_lookup_t nxt;

	// A held strobe only counts while the port has nothing in flight
	assign req_ld = ld_cyc & ld_stb & ~inflight_q[LC_PORT_LD];
	assign req_wr = wr_cyc & wr_stb & ~inflight_q[LC_PORT_WR];
	assign req_rd = rd_cyc & rd_stb & ~inflight_q[LC_PORT_RD];

	// Fixed priority, load over write over read
	assign issue_vec[LC_PORT_LD] = req_ld;
	assign issue_vec[LC_PORT_WR] = req_wr & ~req_ld;
	assign issue_vec[LC_PORT_RD] = req_rd & ~req_wr & ~req_ld;

	assign done_vec = done ? (3'b001 << done_port) : 3'b000;

	always_comb begin
		nxt = '0;
		sel_adr = rd_adr;
		if (req_ld) begin
			nxt.valid = 1'b1;
			nxt.op    = LC_OP_LOAD;
			nxt.port  = LC_PORT_LD;
			nxt.sel   = '1; // A fill replaces the whole line
			nxt.line  = ld_dat;
			nxt.way   = ld_way;
			sel_adr   = ld_adr;
		end else if (req_wr) begin
			nxt.valid = 1'b1;
			// No byte selects with inv set means invalidate
			nxt.op    = (wr_inv && wr_sel == '0) ? LC_OP_INVAL : LC_OP_WRITE;
			nxt.port  = LC_PORT_WR;
			nxt.sel   = wr_sel;
			nxt.line  = wr_dat;
			sel_adr   = wr_adr;
		end else if (req_rd) begin
			nxt.valid = 1'b1;
			nxt.op    = LC_OP_READ;
			nxt.port  = LC_PORT_RD;
		end
		// Byte offset bits are dropped, the cache works on whole lines
		nxt.tag   = sel_adr[31 -: LC_TAG_BITS];
		nxt.index = sel_adr[LC_OFS_BITS +: LC_IDX_BITS];
	end

	// ========================================
	// Stage register and in-flight tracking
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst) begin
			inflight_q   <= 3'b000;
			lookup.valid <= 1'b0;
		end else begin
			inflight_q <= (inflight_q & ~done_vec) | issue_vec; // Set on grant, clear on answer
			lookup     <= nxt;
		end
	end

	// An answer from the result stage always belongs to a port that has an item in flight
	assert property (@(posedge wclk) disable iff (rst) done |-> inflight_q[done_port]);

endmodule

`default_nettype wire

// File: hdl/lcache_way_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcache_consts.svh"

module lcache_way_store (
	input  logic                   wclk,
	input  logic                   rst,
	input  lcache_pkg::lc_lookup_t lookup,
	output lcache_pkg::lc_result_t result
);
	import lcache_pkg::*;

	// ========================================
	// Arrays, one entry per way and set
	// ========================================
	lc_tag_t          tag_mem [`LC_WAYS][`LC_SETS];
	lc_line_t         dat_mem [`LC_WAYS][`LC_SETS];
	logic [`LC_SETS-1:0] vld_mem [`LC_WAYS]; // One valid bit per set in each way

	// Write buffer, it holds the entry produced by the item that just left this stage
	// and lands in the arrays on the following edge
	logic      wb_en;
	lc_way_t   wb_way;
	lc_index_t wb_index;
	lc_tag_t   wb_tag;
	logic      wb_vld;
	lc_line_t  wb_line;

	// Entries seen by the current lookup after forwarding
	lc_tag_t  eff_tag [`LC_WAYS];
	lc_line_t eff_line [`LC_WAYS];
	logic [`LC_WAYS-1:0] eff_vld;
	logic [`LC_WAYS-1:0] hit_vec;

	lc_way_t  hit_way;
	lc_line_t hit_line;
	lc_line_t merged;   // Hit line with the selected write bytes replaced

	// Entry that this item wants written
	logic     upd_en;
	lc_way_t  upd_way;
	lc_tag_t  upd_tag;
	logic     upd_vld;
	lc_line_t upd_line;

	// Same set and same way as the pending write means the array is one edge stale
	always_comb begin
		for (int w = 0; w < `LC_WAYS; w++) begin
			if (wb_en && wb_index == lookup.index && wb_way == lc_way_t'(w)) begin
				eff_tag[w]  = wb_tag;
				eff_line[w] = wb_line;
				eff_vld[w]  = wb_vld;
			end else begin
				eff_tag[w]  = tag_mem[w][lookup.index];
				eff_line[w] = dat_mem[w][lookup.index];
				eff_vld[w]  = vld_mem[w][lookup.index];
			end
			hit_vec[w] = eff_vld[w] && eff_tag[w] == lookup.tag; // Compare in all ways at once
		end
	end

	// Encode the hit way and pick its line
	always_comb begin
		hit_way  = '0;
		hit_line = '0;
		for (int w = 0; w < `LC_WAYS; w++) begin
			if (hit_vec[w]) begin
				hit_way  = lc_way_t'(w);
				hit_line = eff_line[w];
			end
		end
		for (int b = 0; b < `LC_LINE_BYTES; b++)
			merged[b*8 +: 8] = lookup.sel[b] ? lookup.line[b*8 +: 8] : hit_line[b*8 +: 8];
	end

	// What each operation does to the arrays, misses leave them alone
	always_comb begin
		upd_en   = 1'b0;
		upd_way  = hit_way;
		upd_tag  = lookup.tag;
		upd_vld  = 1'b1;
		upd_line = merged;
		case (lookup.op)
			LC_OP_LOAD: begin
				upd_en   = 1'b1;
				upd_way  = lookup.way;  // The loader picks the way, no replacement policy
				upd_line = lookup.line;
			end
			LC_OP_WRITE: upd_en = |hit_vec;
			LC_OP_INVAL: begin
				upd_en   = |hit_vec;
				upd_vld  = 1'b0;        // Tag and data stay, only the valid bit drops
				upd_line = hit_line;
			end
			default: upd_en = 1'b0;     // Reads change nothing
		endcase
	end

	// ========================================
	// Stage register, write buffer and arrays
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst) begin
			result.valid <= 1'b0;
			wb_en        <= 1'b0;
			for (int w = 0; w < `LC_WAYS; w++)
				vld_mem[w] <= '0;
		end else begin
			result.valid <= lookup.valid;
			result.op    <= lookup.op;
			result.port  <= lookup.port;
			result.hit   <= |hit_vec;
			result.way   <= hit_way;
			result.line  <= hit_line;
			wb_en        <= lookup.valid && upd_en;
			if (wb_en)
				vld_mem[wb_way][wb_index] <= wb_vld;
		end
	end

	always_ff @(posedge wclk) begin
		wb_way   <= upd_way;
		wb_index <= lookup.index;
		wb_tag   <= upd_tag;
		wb_vld   <= upd_vld;
		wb_line  <= upd_line;
		if (wb_en) begin
			tag_mem[wb_way][wb_index] <= wb_tag;
			dat_mem[wb_way][wb_index] <= wb_line;
		end
	end

	// Loads and forwarding together must never leave the same tag valid in two ways
	assert property (@(posedge wclk) disable iff (rst) lookup.valid |-> $onehot0(hit_vec));

	// The loader only names ways that exist
	assert property (@(posedge wclk) disable iff (rst)
		(lookup.valid && lookup.op == LC_OP_LOAD) |-> (lookup.way < `LC_WAYS));

endmodule

`default_nettype wire

// File: hdl/lcache_resp.sv
`timescale 1ns/1ps
`default_nettype none

module lcache_resp (
	input  logic                   wclk,
	input  logic                   rst,
	input  lcache_pkg::lc_result_t result,
	output logic                   rd_ack,
	output logic                   rd_err,
	output logic                   wr_ack,
	output logic                   ld_ack,
	output lcache_pkg::lc_line_t   rd_dat,
	output lcache_pkg::lc_way_t    rd_way,
	output logic                   done,
	output lcache_pkg::lc_port_e   done_port
);
	import lcache_pkg::*;

	logic is_rd; // Live result for the read port
	logic is_wr;
	logic is_ld;

	assign is_rd = result.valid && result.port == LC_PORT_RD;
	assign is_wr = result.valid && result.port == LC_PORT_WR;
	assign is_ld = result.valid && result.port == LC_PORT_LD;

	// ========================================
	// Port handshake
	// ========================================
	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_ack <= 1'b0;
			rd_err <= 1'b0;
			wr_ack <= 1'b0;
			ld_ack <= 1'b0;
			done   <= 1'b0;
		end else begin
			rd_ack <= is_rd && result.hit;  // Read hit
			rd_err <= is_rd && !result.hit; // Read miss, the controller must fill the line
			wr_ack <= is_wr;                // Write misses are acked too, memory takes the write
			ld_ack <= is_ld;
			done   <= result.valid;         // Lets decode clear the in-flight bit
		end
	end

	// Read payload, only meaningful while rd_ack or rd_err is high
	always_ff @(posedge wclk) begin
		rd_dat    <= (is_rd && result.hit) ? result.line : '0; // A miss returns zeros
		rd_way    <= result.way;
		done_port <= result.port;
	end

	// One answer per read, never both
	assert property (@(posedge wclk) disable iff (rst) !(rd_ack && rd_err));

endmodule

`default_nettype wire

// File: hdl/lcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcache_top (
	input  logic                 wclk,
	input  logic                 rst,
	// Read port
	input  logic                 rd_cyc,
	input  logic                 rd_stb,
	input  lcache_pkg::lc_addr_t rd_adr,
	output logic                 rd_ack,
	output logic                 rd_err,
	output lcache_pkg::lc_line_t rd_dat,
	output lcache_pkg::lc_way_t  rd_way,
	// Write port
	input  logic                 wr_cyc,
	input  logic                 wr_stb,
	input  logic                 wr_inv,
	input  lcache_pkg::lc_addr_t wr_adr,
	input  lcache_pkg::lc_sel_t  wr_sel,
	input  lcache_pkg::lc_line_t wr_dat,
	output logic                 wr_ack,
	// Load port
	input  logic                 ld_cyc,
	input  logic                 ld_stb,
	input  lcache_pkg::lc_addr_t ld_adr,
	input  lcache_pkg::lc_line_t ld_dat,
	input  lcache_pkg::lc_way_t  ld_way,
	output logic                 ld_ack
);
	import lcache_pkg::*;

	lc_lookup_t lookup;    // Decode to way store
	lc_result_t result;    // Way store to result
	logic       done;      // Result back to decode
	lc_port_e   done_port;

	lcache_req_decode u_decode (.wclk, .rst, .rd_cyc, .rd_stb, .wr_cyc, .wr_stb, .wr_inv,
		.ld_cyc, .ld_stb, .rd_adr, .wr_adr, .ld_adr, .wr_sel, .wr_dat, .ld_dat, .ld_way,
		.done_port, .done, .lookup);

	lcache_way_store u_store (.wclk, .rst, .lookup, .result);

	lcache_resp u_resp (.wclk, .rst, .result, .rd_ack, .rd_err, .wr_ack, .ld_ack,
		.rd_dat, .rd_way, .done, .done_port);

endmodule

`default_nettype wire

// File: testbench/tb_lcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcache_consts.svh"

module tb_lcache;
	import lcache_pkg::*;

	// ========================================
	// Run length and watchdog
	// ========================================
	localparam int N_DIRECTED = 20; // Requests issued by the directed part
	localparam int N_RAND     = 60; // Random requests on each port
	localparam int N_REQ      = N_DIRECTED + 3 * N_RAND;
	localparam int WD_CYCLES  = N_REQ * (`LC_PIPE_DEPTH + 4) + 200; // Last term is margin

	// One read answer, expected or seen on the port
	typedef struct packed {
		logic     hit;
		lc_way_t  way;
		lc_line_t line;
	} rd_res_t;

	logic     wclk;
	logic     rst;
	logic     rd_cyc, rd_stb, rd_ack, rd_err; // Read port
	lc_addr_t rd_adr;
	lc_line_t rd_dat;
	lc_way_t  rd_way;
	logic     wr_cyc, wr_stb, wr_inv, wr_ack; // Write port
	lc_addr_t wr_adr;
	lc_sel_t  wr_sel;
	lc_line_t wr_dat;
	logic     ld_cyc, ld_stb, ld_ack;         // Load port
	lc_addr_t ld_adr;
	lc_line_t ld_dat;
	lc_way_t  ld_way;

	// Reference arrays with one entry per way and set
	lc_tag_t  m_tag  [`LC_WAYS][`LC_SETS];
	lc_line_t m_line [`LC_WAYS][`LC_SETS];
	logic     m_vld  [`LC_WAYS][`LC_SETS];

	int n_err;
	int n_chk;
	int req_cnt  [3]; // Strobes raised per port, indexed like lc_port_e
	int done_cnt [3]; // Answers seen per port

	lcache_top lcache_top_i (.*);

	initial begin
		wclk = 1'b0;
		forever #2 wclk = ~wclk; // 4 ns period
	end

	// ========================================
	// Reference model
	// ========================================
	function automatic lc_addr_t make_adr(input int tag, input int set, input int ofs);
		return {tag[22:0], set[4:0], ofs[3:0]}; // Tag 31 to 9, set 8 to 4, byte 3 to 0
	endfunction

	// Looks the address up in every way of its set, a miss gives all zeros
	function automatic rd_res_t expect_read(input lc_addr_t adr);
		rd_res_t r;
		r = '0;
		for (int w = 0; w < `LC_WAYS; w++) begin
			if (m_vld[w][adr[8:4]] && m_tag[w][adr[8:4]] == adr[31:9]) begin
				r.hit  = 1'b1;
				r.way  = lc_way_t'(w);
				r.line = m_line[w][adr[8:4]];
			end
		end
		return r;
	endfunction

	function automatic void apply_load(input lc_addr_t adr, input lc_way_t way, input lc_line_t dat);
		m_tag[way][adr[8:4]]  = adr[31:9];
		m_line[way][adr[8:4]] = dat;
		m_vld[way][adr[8:4]]  = 1'b1; // Whole line replaced in the named way
	endfunction

	// Write or invalidate on a hit, a miss goes through to memory and changes nothing here
	function automatic void apply_write(input lc_addr_t adr, input lc_sel_t sel,
			input lc_line_t dat, input logic inv);
		rd_res_t r;
		r = expect_read(adr);
		if (r.hit && inv && sel == '0) begin
			m_vld[r.way][adr[8:4]] = 1'b0;
		end else if (r.hit) begin
			for (int b = 0; b < `LC_LINE_BYTES; b++)
				if (sel[b])
					m_line[r.way][adr[8:4]][b*8 +: 8] = dat[b*8 +: 8];
		end
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] want);
		n_chk++;
		if (got !== want) begin
			n_err++;
			$display("FAILED %s at %0t: got %h expected %h", name, $time, got, want);
		end
	endtask

	task automatic report_error(input string what);
		n_err++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	// ========================================
	// Wishbone masters, inputs change on the falling edge
	// ========================================
	task automatic read_line(input lc_addr_t adr, output rd_res_t got, output int lat);
		@(negedge wclk);
		rd_adr = adr;
		rd_cyc = 1'b1;
		rd_stb = 1'b1;
		req_cnt[LC_PORT_RD]++;
		lat = 0;
		do begin
			@(negedge wclk);
			lat++; // Rising edges since the strobe went up
		end while (!(rd_ack || rd_err));
		got.hit  = rd_ack;
		got.way  = rd_way;
		got.line = rd_dat;
		rd_cyc = 1'b0;
		rd_stb = 1'b0; // Address held until the next request
	endtask

	task automatic write_bytes(input lc_addr_t adr, input lc_sel_t sel, input lc_line_t dat,
			input logic inv, output int lat);
		@(negedge wclk);
		wr_adr = adr;
		wr_sel = sel;
		wr_dat = dat;
		wr_inv = inv;
		wr_cyc = 1'b1;
		wr_stb = 1'b1;
		req_cnt[LC_PORT_WR]++;
		lat = 0;
		do begin
			@(negedge wclk);
			lat++;
		end while (!wr_ack);
		wr_cyc = 1'b0;
		wr_stb = 1'b0;
	endtask

	task automatic load_line(input lc_addr_t adr, input lc_way_t way, input lc_line_t dat,
			output int lat);
		@(negedge wclk);
		ld_adr = adr;
		ld_way = way;
		ld_dat = dat;
		ld_cyc = 1'b1;
		ld_stb = 1'b1;
		req_cnt[LC_PORT_LD]++;
		lat = 0;
		do begin
			@(negedge wclk);
			lat++;
		end while (!ld_ack);
		ld_cyc = 1'b0;
		ld_stb = 1'b0;
	endtask

	// Answers arrive in issue order, one per cycle, so the model is applied as they come
	initial begin
		rd_res_t want;
		forever begin
			@(negedge wclk);
			if (int'(rd_ack | rd_err) + int'(wr_ack) + int'(ld_ack) > 1)
				report_error("more than one port answered in the same cycle");
			if (ld_ack) begin
				done_cnt[LC_PORT_LD]++;
				apply_load(ld_adr, ld_way, ld_dat);
			end
			if (wr_ack) begin
				done_cnt[LC_PORT_WR]++;
				apply_write(wr_adr, wr_sel, wr_dat, wr_inv);
			end
			if (rd_ack || rd_err) begin
				done_cnt[LC_PORT_RD]++;
				want = expect_read(rd_adr);
				check_value("rd_ack", rd_ack, want.hit);
				check_value("rd_err", rd_err, !want.hit);
				check_value("rd_dat", rd_dat, want.line); // Zeros on a miss
				if (want.hit)
					check_value("rd_way", rd_way, want.way);
			end
			for (int p = 0; p < 3; p++)
				if (done_cnt[p] > req_cnt[p])
					report_error($sformatf("port %0d answered without a request", p));
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge wclk);
		$display("Watchdog expired after %0d cycles, a request was never answered", WD_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ========================================
	// Directed tests, then random traffic
	// ========================================
	initial begin
		rd_res_t  got;
		int       lat;
		int       lat_b;
		lc_line_t l1, l2, wd, mask;
		lc_addr_t a1, a2, a3;
		void'($urandom(32'hf72a7159));
		{rd_cyc, rd_stb, wr_cyc, wr_stb, wr_inv, ld_cyc, ld_stb} = '0;
		{rd_adr, wr_adr, ld_adr} = '0;
		{wr_sel, wr_dat, ld_dat, ld_way} = '0;
		n_err = 0;
		n_chk = 0;
		for (int p = 0; p < 3; p++) begin
			req_cnt[p]  = 0;
			done_cnt[p] = 0;
		end
		for (int w = 0; w < `LC_WAYS; w++)
			for (int s = 0; s < `LC_SETS; s++)
				m_vld[w][s] = 1'b0;
		rst = 1'b1;
		repeat (2) @(negedge wclk); // Two rising edges in reset
		rst = 1'b0;
		repeat (3) begin
			@(negedge wclk);
			check_value("acks after reset", {rd_ack, rd_err, wr_ack, ld_ack}, 4'b0);
		end

		a1 = make_adr(23'h1a2b3, 5, 0);
		a2 = make_adr(23'h00457, 5, 0); // Same set, other way
		l1 = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
		l2 = 128'h11223344_55667788_99aabbcc_ddeeff00;
		wd = 128'hdeadbeef_cafef00d_01234567_89abcdef;
		read_line(a1, got, lat);
		check_value("rd_err on empty cache", !got.hit, 1'b1);
		check_value("read miss latency", lat, `LC_PIPE_DEPTH);

		load_line(a1, 2'd2, l1, lat);
		check_value("load latency", lat, `LC_PIPE_DEPTH);
		load_line(a2, 2'd0, l2, lat);
		for (int o = 0; o < 16; o += 5) begin
			read_line(a1 + o, got, lat); // Any byte of the line hits
			check_value("rd_dat of loaded line", got.line, l1);
			check_value("rd_way of loaded line", got.way, 2'd2);
		end

		mask = {64'h0, 32'hffff_ffff, 32'h0}; // Bytes 4 to 7
		write_bytes(a1 + 4, 16'h00f0, wd, 1'b0, lat);
		read_line(a1, got, lat);
		check_value("rd_dat after partial write", got.line, (l1 & ~mask) | (wd & mask));

		a3 = make_adr(23'h7f001, 5, 0); // Tag never loaded
		write_bytes(a3, 16'hffff, ~l1, 1'b0, lat);
		check_value("write miss latency", lat, `LC_PIPE_DEPTH);
		read_line(a1, got, lat);
		check_value("rd_dat after write miss", got.line, (l1 & ~mask) | (wd & mask));
		read_line(a2, got, lat);
		check_value("other way after write miss", got.line, l2);
		read_line(a3, got, lat);
		check_value("rd_err for missed write", !got.hit, 1'b1);

		write_bytes(a1, 16'h0000, '0, 1'b1, lat); // Invalidate
		read_line(a1, got, lat);
		check_value("rd_err after invalidate", !got.hit, 1'b1);
		read_line(a2, got, lat);
		check_value("rd_way of surviving way", got.way, 2'd0);

		// Same-cycle strobes, the loser sees the winner's update through forwarding
		a3 = make_adr(23'h0abcd, 7, 8);
		fork
			load_line(a3, 2'd1, ~l2, lat);
			read_line(a3, got, lat_b);
		join
		check_value("rd_dat behind a load", got.line, ~l2);
		check_value("read latency after losing", lat_b, `LC_PIPE_DEPTH + 1);
		mask = {64'hffff_ffff_ffff_ffff, 64'h0};
		fork
			write_bytes(a3, 16'hff00, wd, 1'b0, lat);
			read_line(a3, got, lat_b);
		join
		check_value("rd_dat behind a write", got.line, (~l2 & ~mask) | (wd & mask));

		// Each random tag k lives only in way k, so no tag is ever valid in two ways
		fork
			begin
				int lt;
				int k;
				repeat (N_RAND) begin
					k = $urandom_range(0, 3);
					repeat ($urandom_range(0, 2)) @(negedge wclk);
					load_line(make_adr(23'h2a000 + k, $urandom_range(0, 3), $urandom), lc_way_t'(k),
						{$urandom, $urandom, $urandom, $urandom}, lt);
				end
			end
			begin
				int   lt;
				int   k;
				logic inv;
				repeat (N_RAND) begin
					k   = $urandom_range(0, 4); // Tag 4 is never loaded
					inv = ($urandom_range(0, 4) == 0);
					repeat ($urandom_range(0, 2)) @(negedge wclk);
					write_bytes(make_adr(23'h2a000 + k, $urandom_range(0, 3), $urandom),
						inv ? '0 : lc_sel_t'($urandom), {$urandom, $urandom, $urandom, $urandom},
						inv, lt);
				end
			end
			begin
				int      lt;
				rd_res_t r;
				repeat (N_RAND) begin
					repeat ($urandom_range(0, 2)) @(negedge wclk);
					read_line(make_adr(23'h2a000 + $urandom_range(0, 4), $urandom_range(0, 3),
						$urandom), r, lt);
				end
			end
		join
		repeat (4) @(negedge wclk);

		for (int p = 0; p < 3; p++)
			if (req_cnt[p] != done_cnt[p])
				report_error($sformatf("port %0d raised %0d requests and got %0d answers",
					p, req_cnt[p], done_cnt[p]));
		$display("Closing: %0d checks, %0d errors", n_chk, n_err);
		if (n_err == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/lcache_pkg.sv
hdl/lcache_req_decode.sv
hdl/lcache_way_store.sv
hdl/lcache_resp.sv
hdl/lcache_top.sv
testbench/tb_lcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and judges the run from its log
set -u
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_lcache

rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module tb_lcache -f src.f \
	-Mdir obj_dir -o sim_lcache \
	&& "./$BIN" 2>&1 | tee "$LOG" \
	|| echo "Build or simulation ended with an error status"

[ -f "$LOG" ] || { echo "No log written, the build failed"; exit 1; }
grep -qF '*** TEST FAILED ***' "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -qF '*** TEST PASSED ***' "$LOG" || { echo "No pass line in $LOG"; exit 1; }
echo "Simulation passed"
